/* include/subsys_config.svh */
////////////////////////////////////////
// Timing and register map constants. PWM_PRESCALE must be 2 or more.
// FRAME_BITS stays 8 so that phase, widths and register bytes line up.
////////////////////////////////////////
`ifndef SUBSYS_CONFIG_SVH
`define SUBSYS_CONFIG_SVH

// Timebase
`define PWM_PRESCALE    4               // Clocks per tick
`define FRAME_BITS      8               // Phase width, 256 ticks per frame

// Pulse shaping
`define DRIVE_NEUTRAL   128             // Drive width at zero magnitude, ticks
`define DRIVE_GAIN      4               // Ticks per magnitude step
`define SERVO_START     8'd5            // Servo position out of reset

`define NUM_MOTORS      4               // Drive and servo channel count
`define SUBSYS_ID       8'hA5           // Read-only identity byte

// Register map
`define REG_DRIVE0      6'h00           // Drives at 0x00 to 0x03
`define REG_SERVO_EN    6'h04           // Servo enables in bits 3:0
`define REG_SERVO0      6'h08           // Servo targets at 0x08 to 0x0B
`define REG_LED         6'h0C           // Brightness and flag bits
`define REG_ID          6'h10           // Identity, read only

`endif

/* src/subsys_pkg.sv */
////////////////////////////////////////
// Bus, configuration and timebase types shared by all blocks
////////////////////////////////////////
`include "subsys_config.svh"

package subsys_pkg;

    typedef logic [5:0] reg_addr_t;     // Register address
    typedef logic [7:0] reg_byte_t;     // Register word

    // Host request, one access per clock at most
    typedef struct packed {
        reg_addr_t  address;            // Target register
        logic       write_en;           // Write strobe
        reg_byte_t  wr_data;            // Write payload
        logic       read_en;            // Read strobe
    } reg_req_t;

    // Drive register as seen by a drive channel
    typedef struct packed {
        logic       enable;             // Bit 7, output off when clear
        logic       direction;          // Bit 6, 1 widens the pulse
        logic       spare;              // Bit 5, stored only
        logic [4:0] magnitude;          // Bits 4:0
    } drive_cmd_t;

    // Register file keeps the raw byte, channel reads the fields
    typedef union packed {
        reg_byte_t  raw;
        drive_cmd_t fields;
    } drive_word_u;

    // LED register bits 6:0, bit 7 unused
    typedef struct packed {
        logic [3:0] brightness;         // Bits 6:3, width is 16 ticks per step
        logic       fault;              // Bit 2
        logic       pi;                 // Bit 1
        logic       ps4;                // Bit 0
    } led_cfg_t;

    // Shared pulse timebase
    typedef struct packed {
        logic                   tick;           // One clock per prescale period
        logic                   frame_start;    // First clock of phase zero
        logic [`FRAME_BITS-1:0] phase;          // Tick count within the frame
    } timebase_t;

endpackage

/* src/ctrl_regs.sv */
////////////////////////////////////////
// Host register file. Read data lands one clock after read_en and holds.
// Channel decode assumes four drives and four servos per group.
////////////////////////////////////////
`include "subsys_config.svh"

module ctrl_regs import subsys_pkg::*; (
    input  logic                            clock,
    input  logic                            reset_n,
    input  reg_req_t                        reg_req,        // Host request
    output reg_byte_t                       rd_data,        // Registered read data
    output drive_word_u [`NUM_MOTORS-1:0]   drive_cmd,      // Drive commands
    output logic        [`NUM_MOTORS-1:0]   servo_en,       // Servo enables
    output reg_byte_t   [`NUM_MOTORS-1:0]   servo_target,   // Servo targets
    output led_cfg_t                        led_cfg         // LED config
);

    localparam reg_addr_t GROUP_MASK = 6'h3C;   // Drops the channel index bits

    reg_byte_t  servo_en_q;                     // Full byte kept for readback
    reg_byte_t  led_q;                          // Full byte kept for readback
    reg_byte_t  rd_mux;                         // Read data before the register
    logic [1:0] sel;                            // Channel within a group
    logic       hit_drive;                      // Address in drive group
    logic       hit_servo;                      // Address in servo target group

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign sel       = reg_req.address[1:0];
    assign hit_drive = (reg_req.address & GROUP_MASK) == `REG_DRIVE0;
    assign hit_servo = (reg_req.address & GROUP_MASK) == `REG_SERVO0;

    ////////////////////////////////////////
    // Writable registers
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            drive_cmd    <= '0;                 // All drives disabled
            servo_target <= '0;
            servo_en_q   <= '0;
            led_q        <= '0;                 // LEDs dark
        end else if (reg_req.write_en) begin
            if (hit_drive) begin
                drive_cmd[sel].raw <= reg_req.wr_data;
            end else if (hit_servo) begin
                servo_target[sel] <= reg_req.wr_data;
            end else if (reg_req.address == `REG_SERVO_EN) begin
                servo_en_q <= reg_req.wr_data;
            end else if (reg_req.address == `REG_LED) begin
                led_q <= reg_req.wr_data;
            end                                 // REG_ID and holes ignored
        end
    end

    // Read mux, unmapped addresses give zero
    always_comb begin
        rd_mux = '0;
        if (hit_drive) begin
            rd_mux = drive_cmd[sel].raw;
        end else if (hit_servo) begin
            rd_mux = servo_target[sel];
        end else if (reg_req.address == `REG_SERVO_EN) begin
            rd_mux = servo_en_q;
        end else if (reg_req.address == `REG_LED) begin
            rd_mux = led_q;
        end else if (reg_req.address == `REG_ID) begin
            rd_mux = `SUBSYS_ID;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (reg_req.read_en) begin
            rd_data <= rd_mux;                  // Holds until the next read
        end
    end

    assign servo_en = servo_en_q[`NUM_MOTORS-1:0];              // Low bits only
    assign led_cfg  = led_cfg_t'(led_q[$bits(led_cfg_t)-1:0]);  // Bit 7 not used

endmodule

/* src/motor_timebase.sv */
////////////////////////////////////////
// Shared tick and frame phase. Phase is zero out of reset,
// first frame_start comes one full frame later.
////////////////////////////////////////
`include "subsys_config.svh"

module motor_timebase import subsys_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    output timebase_t   timebase            // Tick, frame start and phase
);

    localparam int PS_W = $clog2(`PWM_PRESCALE);

    logic [PS_W-1:0] ps_cnt;                // Prescale counter
    logic            ps_wrap;               // Last clock of a tick period

    assign ps_wrap = ps_cnt == PS_W'(`PWM_PRESCALE - 1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ps_cnt   <= '0;
            timebase <= '0;
        end else begin
            ps_cnt               <= ps_wrap ? '0 : ps_cnt + 1'b1;
            timebase.tick        <= ps_wrap;            // First clock of new phase
            // Phase about to wrap to zero
            timebase.frame_start <= ps_wrap && (timebase.phase == '1);
            if (ps_wrap) begin
                timebase.phase <= timebase.phase + 1'b1;
            end
        end
    end

endmodule

/* src/drive_pwm.sv */
////////////////////////////////////////
// Neutral-centred drive pulse. Commands apply from the next frame start,
// output trails phase by one clock.
////////////////////////////////////////
`include "subsys_config.svh"

module drive_pwm import subsys_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  timebase_t   timebase,           // Shared timebase
    input  drive_word_u cmd,                // Live register value
    output logic        pwm_signal          // Drive pulse
);

    localparam int W = `FRAME_BITS;

    drive_word_u  cmd_q;                    // Command held for the frame
    drive_word_u  cmd_live;                 // Command in force this clock
    logic [W-1:0] offset;                   // Gain times magnitude
    logic [W-1:0] width;                    // Pulse width in ticks

    // New command takes over on the frame start clock itself
    assign cmd_live = timebase.frame_start ? cmd : cmd_q;
    assign offset   = W'(`DRIVE_GAIN * cmd_live.fields.magnitude);

    always_comb begin
        if (cmd_live.fields.direction) begin
            width = W'(`DRIVE_NEUTRAL) + offset;    // Forward, wider pulse
        end else begin
            width = W'(`DRIVE_NEUTRAL) - offset;    // Reverse, narrower pulse
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cmd_q      <= '0;
            pwm_signal <= 1'b0;
        end else begin
            cmd_q      <= cmd_live;
            pwm_signal <= cmd_live.fields.enable && (timebase.phase < width);
        end
    end

endmodule

/* src/servo_ramp.sv */
////////////////////////////////////////
// Servo pulse ramping one tick of width per frame toward its target.
// Disable parks the position at SERVO_START.
////////////////////////////////////////
`include "subsys_config.svh"

module servo_ramp import subsys_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  timebase_t   timebase,           // Shared timebase
    input  logic        enable,             // Servo enable
    input  reg_byte_t   target,             // Target position in ticks
    output logic        pwm_signal          // Servo pulse
);

    localparam int W = `FRAME_BITS;

    reg_byte_t pos_q;                       // Current position
    reg_byte_t pos_next;                    // Position after this clock

    always_comb begin
        pos_next = pos_q;
        if (!enable) begin
            pos_next = `SERVO_START;        // Parked while off
        end else if (timebase.frame_start) begin
            if (pos_q < target) begin
                pos_next = pos_q + 1'b1;    // Step up
            end else if (pos_q > target) begin
                pos_next = pos_q - 1'b1;    // Step down
            end
        end
    end

    ////////////////////////////////////////
    // Position and pulse
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pos_q      <= `SERVO_START;
            pwm_signal <= 1'b0;
        end else begin
            pos_q      <= pos_next;
            // Next value so the whole frame uses the stepped width
            pwm_signal <= enable && (timebase.phase < W'(pos_next));
        end
    end

endmodule

/* src/status_leds.sv */
////////////////////////////////////////
// LED dimmer, width is brightness times 16 ticks
////////////////////////////////////////
`include "subsys_config.svh"

module status_leds import subsys_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  timebase_t   timebase,           // Shared timebase
    input  led_cfg_t    led_cfg,            // Brightness and flags
    output logic        status_fault,       // Fault LED
    output logic        status_pi,          // Host link LED
    output logic        status_ps4,         // Controller link LED
    output logic        status_debug        // Raw dimmer wave
);

    localparam int W = `FRAME_BITS;

    logic [W-1:0] dim_width;                // Dimmer width in ticks
    logic         dim_wave;                 // Registered dimmer wave

    assign dim_width = W'({led_cfg.brightness, 4'b0000});

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dim_wave <= 1'b0;
        end else if (timebase.tick) begin
            dim_wave <= timebase.phase < dim_width;     // Sampled once per phase step
        end
    end

    assign status_debug = dim_wave;
    assign status_fault = dim_wave & led_cfg.fault;
    assign status_pi    = dim_wave & led_cfg.pi;
    assign status_ps4   = dim_wave & led_cfg.ps4;

endmodule

/* src/fpga_subsystem.sv */
////////////////////////////////////////
// Motor and LED subsystem top. Host drives the register bus directly.
////////////////////////////////////////
`include "subsys_config.svh"

module fpga_subsystem import subsys_pkg::*; (
    input  logic                        clock,
    input  logic                        reset_n,
    input  reg_req_t                    reg_req,        // Host request
    output reg_byte_t                   rd_data,        // Host read data
    output logic [`NUM_MOTORS-1:0]      sd_pwm,         // Drive motor pulses
    output logic [`NUM_MOTORS-1:0]      servo_pwm,      // Arm servo pulses
    output logic                        status_fault,
    output logic                        status_pi,
    output logic                        status_ps4,
    output logic                        status_debug
);

    drive_word_u [`NUM_MOTORS-1:0]  drive_cmd;          // Per drive command
    logic        [`NUM_MOTORS-1:0]  servo_en;           // Per servo enable
    reg_byte_t   [`NUM_MOTORS-1:0]  servo_target;       // Per servo target
    led_cfg_t                       led_cfg;
    timebase_t                      timebase;

    ////////////////////////////////////////
    // Registers and timebase
    ////////////////////////////////////////
    ctrl_regs u_regs (
        .clock          (clock),
        .reset_n        (reset_n),
        .reg_req        (reg_req),
        .rd_data        (rd_data),
        .drive_cmd      (drive_cmd),
        .servo_en       (servo_en),
        .servo_target   (servo_target),
        .led_cfg        (led_cfg)
    );

    motor_timebase u_timebase (
        .clock          (clock),
        .reset_n        (reset_n),
        .timebase       (timebase)
    );

    ////////////////////////////////////////
    // Pulse channels
    ////////////////////////////////////////
    for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_drive
        drive_pwm u_drive (
            .clock      (clock),
            .reset_n    (reset_n),
            .timebase   (timebase),
            .cmd        (drive_cmd[i]),
            .pwm_signal (sd_pwm[i])
        );
    end

    for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_servo
        servo_ramp u_servo (
            .clock      (clock),
            .reset_n    (reset_n),
            .timebase   (timebase),
            .enable     (servo_en[i]),
            .target     (servo_target[i]),
            .pwm_signal (servo_pwm[i])
        );
    end

    status_leds u_leds (
        .clock          (clock),
        .reset_n        (reset_n),
        .timebase       (timebase),
        .led_cfg        (led_cfg),
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

endmodule

/* tb/fpga_subsystem_chk.sv */
////////////////////////////////////////
// Assertions bound onto the subsystem top. Reset release is
// expected shortly after a rising clock edge.
////////////////////////////////////////
`include "subsys_config.svh"

module fpga_subsystem_chk import subsys_pkg::*; (
    input logic                     clock,
    input logic                     reset_n,
    input reg_req_t                 reg_req,
    input reg_byte_t                rd_data,
    input logic [`NUM_MOTORS-1:0]   sd_pwm,
    input logic [`NUM_MOTORS-1:0]   servo_pwm,
    input logic                     status_fault,
    input logic                     status_pi,
    input logic                     status_ps4,
    input logic                     status_debug
);
    timeunit 1ns;
    timeprecision 100ps;

    int reset_fails = 0;                    // Pulse seen in reset
    int rd_fails    = 0;                    // Read data not clear after reset
    int bus_fails   = 0;                    // Read and write together
    int fail_count;

    assign fail_count = reset_fails + rd_fails + bus_fails;

    reset_quiet: assert property (@(posedge clock)
        !reset_n |-> (sd_pwm == '0 && servo_pwm == '0 && !status_fault
                      && !status_pi && !status_ps4 && !status_debug))
    else begin
        reset_fails++;
        $error("pulse output high while reset_n is low");
    end

    rd_clear: assert property (@(posedge clock) $rose(reset_n) |-> rd_data == '0)
    else begin
        rd_fails++;
        $error("rd_data not zero after reset release");
    end

    // Strobes are exclusive
    bus_excl: assert property (@(posedge clock) disable iff (!reset_n)
        !(reg_req.write_en && reg_req.read_en))
    else begin
        bus_fails++;
        $error("write_en and read_en high together");
    end

endmodule

bind fpga_subsystem fpga_subsystem_chk u_chk (
    .clock          (clock),
    .reset_n        (reset_n),
    .reg_req        (reg_req),
    .rd_data        (rd_data),
    .sd_pwm         (sd_pwm),
    .servo_pwm      (servo_pwm),
    .status_fault   (status_fault),
    .status_pi      (status_pi),
    .status_ps4     (status_ps4),
    .status_debug   (status_debug)
);

/* tb/fpga_subsystem_tb.sv */
////////////////////////////////////////
// Testbench for the motor and LED subsystem. Pulse widths are counted
// in clocks from a rising edge, sampled on the falling clock edge.
////////////////////////////////////////
`include "subsys_config.svh"

module fpga_subsystem_tb import subsys_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CLKS  = (1 << `FRAME_BITS) * `PWM_PRESCALE;  // Clocks per frame
    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * 20 * FRAME_CLKS * 10;    // Twenty frames a test
    localparam int KIND_DRIVE  = 0;
    localparam int KIND_SERVO  = 1;
    localparam int KIND_LED    = 2;

    // One pending comparison
    typedef struct {
        bit     is_width;                   // Width count, else register byte
        string  name;
        int     expected;
        int     actual;
    } result_t;

    logic                   clock;
    logic                   reset_n;
    reg_req_t               reg_req;
    reg_byte_t              rd_data;
    logic [`NUM_MOTORS-1:0] sd_pwm;
    logic [`NUM_MOTORS-1:0] servo_pwm;
    logic                   status_fault;
    logic                   status_pi;
    logic                   status_ps4;
    logic                   status_debug;
    result_t                results[$];     // Waiting for the compare process
    int                     errors = 0;
    int                     checks = 0;
    int                     test_errors;    // Error count at test start

    fpga_subsystem DUT (
        .clock          (clock),
        .reset_n        (reset_n),
        .reg_req        (reg_req),
        .rd_data        (rd_data),
        .sd_pwm         (sd_pwm),
        .servo_pwm      (servo_pwm),
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

    always #5 clock = ~clock;               // 10 ns period

    // Expected pulse width in clocks for a register byte
    function automatic int pulse_ref(input int kind, input reg_byte_t value);
        int ticks;
        ticks = 0;
        case (kind)
            KIND_DRIVE: begin
                if (value[7]) begin         // Enable bit
                    ticks = value[6] ? `DRIVE_NEUTRAL + `DRIVE_GAIN * int'(value[4:0])
                                     : `DRIVE_NEUTRAL - `DRIVE_GAIN * int'(value[4:0]);
                end
            end
            KIND_SERVO: ticks = int'(value);                // Position in ticks
            default:    ticks = 16 * int'(value[6:3]);      // Brightness steps
        endcase
        return ticks * `PWM_PRESCALE;
    endfunction

    task automatic check_byte(input string name, input reg_byte_t expected,
                              input reg_byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected 0x%02h got 0x%02h", name, expected, actual);
        end
    endtask

    task automatic check_width(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %s width expected 0x%0h got 0x%0h clocks", name, expected, actual);
        end
    endtask

    function automatic void post(input bit is_width, input string name,
                                 input int expected, input int actual);
        result_t r;
        r.is_width = is_width;
        r.name     = name;
        r.expected = expected;
        r.actual   = actual;
        results.push_back(r);
    endfunction

    // Compare process, drains on every rising edge
    always @(posedge clock) begin : compare
        result_t r;
        while (results.size() > 0) begin
            r = results.pop_front();
            if (r.is_width) begin
                check_width(r.name, r.expected, r.actual);
            end else begin
                check_byte(r.name, reg_byte_t'(r.expected), reg_byte_t'(r.actual));
            end
        end
    end

    ////////////////////////////////////////
    // Bus and measurement helpers
    ////////////////////////////////////////
    task automatic write_reg(input reg_addr_t addr, input reg_byte_t data);
        @(posedge clock);
        #1;
        reg_req = '{address: addr, write_en: 1'b1, wr_data: data, read_en: 1'b0};
        @(posedge clock);
        #1;
        reg_req = '0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_byte_t data);
        @(posedge clock);
        #1;
        reg_req = '{address: addr, write_en: 1'b0, wr_data: 8'h00, read_en: 1'b1};
        @(posedge clock);                   // Read data lands here
        #1;
        reg_req = '0;
        @(negedge clock);
        data = rd_data;
    endtask

    // Outputs 0-3 drives, 4-7 servos, 8 fault, 9 pi, 10 ps4, 11 debug
    function automatic logic out_bit(input int sel);
        case (sel)
            8:       return status_fault;
            9:       return status_pi;
            10:      return status_ps4;
            11:      return status_debug;
            default: return (sel < 4) ? sd_pwm[sel[1:0]] : servo_pwm[sel[1:0]];
        endcase
    endfunction

    function automatic string out_name(input int sel);
        case (sel)
            8:       return "status_fault";
            9:       return "status_pi";
            10:      return "status_ps4";
            11:      return "status_debug";
            default: return $sformatf("%s[%0d]", (sel < 4) ? "sd_pwm" : "servo_pwm", sel % 4);
        endcase
    endfunction

    task automatic measure_width(input int sel, output int count);
        count = 0;
        @(negedge clock);
        while (out_bit(sel)) @(negedge clock);     // Skip a pulse in progress
        while (!out_bit(sel)) @(negedge clock);    // Rising edge
        while (out_bit(sel)) begin
            count++;
            @(negedge clock);
        end
    endtask

    // Clocks in which any masked output is high
    task automatic count_high(input logic [11:0] mask, input int clocks, output int count);
        bit hit;
        count = 0;
        repeat (clocks) begin
            @(negedge clock);
            hit = 1'b0;
            for (int s = 0; s < 12; s++) begin
                if (mask[s] && out_bit(s)) hit = 1'b1;
            end
            if (hit) count++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        @(posedge clock);                   // Let the compare process drain
        @(negedge clock);
        $display("TEST %0d %-16s %s (%0d errors)", num, name,
                 (errors == test_errors) ? "PASS" : "FAIL", errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin : stimulus
        reg_byte_t  value;
        reg_byte_t  drive_val [`NUM_MOTORS];
        reg_addr_t  addr;
        int         width;
        int         highs;
        logic [3:0] bright;
        logic [2:0] flags;
        logic [11:0] quiet;

        void'($urandom(32'he6903c4b));
        clock       = 1'b0;
        reset_n     = 1'b0;
        reg_req     = '0;
        test_errors = 0;

        // 1. Reset state
        count_high(12'hFFF, 16, highs);
        post(1'b1, "outputs in reset", 0, highs);
        @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(negedge clock);
        post(1'b0, "rd_data after reset", 0, int'(rd_data));
        count_high(12'hFFF, 64, highs);
        post(1'b1, "outputs after reset", 0, highs);
        read_reg(`REG_ID, value);
        post(1'b0, "REG_ID", int'(`SUBSYS_ID), int'(value));
        end_test(1, "reset");

        // 2. Register readback
        for (int i = 0; i < 9; i++) begin
            addr  = (i < 4) ? reg_addr_t'(`REG_DRIVE0 + i) :
                    (i < 8) ? reg_addr_t'(`REG_SERVO0 + i - 4) : `REG_LED;
            value = reg_byte_t'($urandom);
            write_reg(addr, value);
            read_reg(addr, drive_val[0]);
            post(1'b0, $sformatf("reg 0x%02h", addr), int'(value), int'(drive_val[0]));
        end
        read_reg(6'h20, value);             // Unmapped
        post(1'b0, "unmapped 0x20", 0, int'(value));
        write_reg(`REG_ID, 8'h3C);          // Must be ignored
        read_reg(`REG_ID, value);
        post(1'b0, "REG_ID after write", int'(`SUBSYS_ID), int'(value));
        end_test(2, "readback");

        // 3. Drive pulses
        repeat (2) begin
            for (int ch = 0; ch < `NUM_MOTORS; ch++) begin
                drive_val[ch] = {1'b1, 7'($urandom)};
                write_reg(reg_addr_t'(`REG_DRIVE0 + ch), drive_val[ch]);
            end
            repeat (2 * FRAME_CLKS) @(posedge clock);
            for (int ch = 0; ch < `NUM_MOTORS; ch++) begin
                measure_width(ch, width);
                post(1'b1, out_name(ch), pulse_ref(KIND_DRIVE, drive_val[ch]), width);
            end
        end
        for (int ch = 0; ch < `NUM_MOTORS; ch++) begin
            write_reg(reg_addr_t'(`REG_DRIVE0 + ch), 8'h00);
        end
        repeat (2 * FRAME_CLKS) @(posedge clock);
        count_high(12'h00F, FRAME_CLKS + 8, highs);
        post(1'b1, "sd_pwm while disabled", 0, highs);
        end_test(3, "drive");

        // 4. Servo ramp, enable lands after the frame's short pulses
        for (int ch = 0; ch < `NUM_MOTORS; ch++) begin
            write_reg(reg_addr_t'(`REG_SERVO0 + ch), `SERVO_START + 8'd3);
        end
        write_reg(`REG_DRIVE0, 8'h80);      // Neutral pulse as frame marker
        measure_width(0, width);
        post(1'b1, "sd_pwm[0] neutral", pulse_ref(KIND_DRIVE, 8'h80), width);
        write_reg(`REG_SERVO_EN, 8'h0F);
        for (int step = 1; step <= 4; step++) begin
            measure_width(4, width);
            value = `SERVO_START + reg_byte_t'((step > 3) ? 3 : step);
            post(1'b1, $sformatf("servo_pwm[0] frame %0d", step),
                 pulse_ref(KIND_SERVO, value), width);
        end
        for (int ch = 1; ch < `NUM_MOTORS; ch++) begin
            measure_width(4 + ch, width);
            post(1'b1, out_name(4 + ch), pulse_ref(KIND_SERVO, `SERVO_START + 8'd3), width);
        end
        write_reg(`REG_SERVO_EN, 8'h00);
        count_high(12'h0F0, FRAME_CLKS + 8, highs);
        post(1'b1, "servo_pwm while disabled", 0, highs);
        end_test(4, "servo");

        // 5. LEDs
        repeat (2) begin
            bright = 4'(1 + $urandom % 15);
            flags  = 3'($urandom);
            value  = {1'b0, bright, flags};
            write_reg(`REG_LED, value);
            repeat (FRAME_CLKS) @(posedge clock);
            measure_width(11, width);
            post(1'b1, "status_debug", pulse_ref(KIND_LED, value), width);
            quiet = '0;
            for (int b = 0; b < 3; b++) begin
                if (flags[b]) begin
                    measure_width(10 - b, width);
                    post(1'b1, out_name(10 - b), pulse_ref(KIND_LED, value), width);
                end else begin
                    quiet[10 - b] = 1'b1;
                end
            end
            if (quiet != '0) begin
                count_high(quiet, FRAME_CLKS + 8, highs);
                post(1'b1, "unflagged LEDs", 0, highs);
            end
        end
        end_test(5, "leds");

        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
src/subsys_pkg.sv
src/ctrl_regs.sv
src/motor_timebase.sv
src/drive_pwm.sv
src/servo_ramp.sv
src/status_leds.sv
src/fpga_subsystem.sv
tb/fpga_subsystem_chk.sv
tb/fpga_subsystem_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = fpga_subsystem_tb
FILELIST  = build.f
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
